//--- Makefile
.PHONY: help test clean

help:
	@echo "make test   build the testbench with Verilator and run the regression"
	@echo "make clean  remove the Verilator build directory"

test:
	verilator --binary --timing --assert -f files.f --top-module tb_mini_mips \
		-Mdir obj_dir -o tb_mini_mips
	./obj_dir/tb_mini_mips

clean:
	rm -rf obj_dir

//--- dv/mini_mips_sva.sv
// trace-port assertions for mini_mips_top, attached to every instance of it through bind
`timescale 1ns/1ps
`default_nettype none

module mini_mips_sva (
    input logic               aclk,
    input logic               arst_n,
    input logic [3:0]         debug_wb_rf_wen,
    input cpu_pkg::reg_addr_t debug_wb_rf_wnum
);
    import cpu_pkg::*;

    // whole word or nothing
    wen_all_or_none: assert property (@(posedge aclk) disable iff (!arst_n)
        debug_wb_rf_wen == 4'h0 || debug_wb_rf_wen == 4'hf)
        else $error("trace write enable %h is neither 0 nor f", debug_wb_rf_wen);

    no_write_to_zero: assert property (@(posedge aclk) disable iff (!arst_n)
        debug_wb_rf_wen != 4'h0 |-> debug_wb_rf_wnum != reg_addr_t'(0))
        else $error("trace shows a write to register 0");

    quiet_in_reset: assert property (@(posedge aclk) !arst_n |-> debug_wb_rf_wen == 4'h0)
        else $error("trace write enable set while in reset");

endmodule

bind mini_mips_top mini_mips_sva i_mini_mips_sva (
    .aclk             (aclk),
    .arst_n           (arst_n),
    .debug_wb_rf_wen  (debug_wb_rf_wen),
    .debug_wb_rf_wnum (debug_wb_rf_wnum)
);

`default_nettype wire

//--- dv/tb_mini_mips.sv
// testbench for mini_mips_top: reference model, directed tests and a checker on the trace port
`timescale 1ns/1ps
`default_nettype none

module tb_mini_mips;
    import cpu_pkg::*;

    localparam word_t       RESET_PC     = 32'h8000_0100;  // non-default, checks the parameter path
    localparam logic [31:0] SEED         = 32'h30677efe;
    localparam int unsigned CLK_PERIOD   = 4;
    localparam int unsigned LATENCY      = 3;
    localparam int unsigned TOTAL_INSTR  = 320;
    localparam int unsigned WATCHDOG_CYC = TOTAL_INSTR * 4 + 200;
    localparam logic [5:0]  R_FUNCTS [11] = '{FN_ADDU, FN_SUBU, FN_AND, FN_OR, FN_XOR, FN_NOR,
                                              FN_SLT, FN_SLTU, FN_SLL, FN_SRL, FN_SRA};
    localparam logic [5:0]  I_OPCODES [7] = '{OPC_ADDIU, OPC_SLTI, OPC_SLTIU, OPC_ANDI,
                                              OPC_ORI, OPC_XORI, OPC_LUI};

    typedef struct packed {
        word_t       pc;
        logic        wr;
        reg_addr_t   dst;
        word_t       data;
        int unsigned due;    // falling-edge count when it must be on the trace
    } trace_t;

    logic       aclk;
    logic       arst_n;
    logic       inst_valid;
    word_t      inst_word;
    word_t      debug_wb_pc;
    word_t      debug_wb_rf_wdata;
    logic [3:0] debug_wb_rf_wen;
    reg_addr_t  debug_wb_rf_wnum;

    word_t       model_rf [NUM_REGS];
    word_t       model_pc;
    trace_t      exp_q [$];
    int unsigned cyc = 0;

    mini_mips_top #(
        .RESET_PC          (RESET_PC)
    ) i_mini_mips_top (
        .aclk              (aclk),
        .arst_n            (arst_n),
        .inst_valid        (inst_valid),
        .inst_word         (inst_word),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_wdata (debug_wb_rf_wdata),
        .debug_wb_rf_wen   (debug_wb_rf_wen),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum)
    );

    initial begin
        aclk = 1'b0;
        forever #(CLK_PERIOD / 2) aclk = ~aclk;
    end

    initial begin : watchdog
        #(WATCHDOG_CYC * CLK_PERIOD);
        fail_run("watchdog expired before the tests finished");
    end

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Regression failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic compare_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) fail_run($sformatf("Mismatch %s: got %h expected %h", name, got, exp));
    endtask

    task automatic compare_reg(input string name, input reg_addr_t got, input reg_addr_t exp);
        if (got !== exp) fail_run($sformatf("Mismatch %s: got %h expected %h", name, got, exp));
    endtask

    task automatic compare_wen(input string name, input logic [3:0] got, input logic [3:0] exp);
        if (got !== exp) fail_run($sformatf("Mismatch %s: got %h expected %h", name, got, exp));
    endtask

    function automatic word_t r_word(input logic [5:0] fn, input reg_addr_t rs,
                                     input reg_addr_t rt, input reg_addr_t rd,
                                     input logic [4:0] sh);
        return {OPC_SPECIAL, rs, rt, rd, sh, fn};
    endfunction

    function automatic word_t i_word(input logic [5:0] opc, input reg_addr_t rs,
                                     input reg_addr_t rt, input logic [15:0] imm);
        return {opc, rs, rt, imm};
    endfunction

    function automatic reg_addr_t rnd_reg(input int unsigned lo, input int unsigned hi);
        return reg_addr_t'($urandom_range(hi, lo));
    endfunction

    // MIPS32 semantics of one word against the model registers
    function automatic trace_t model_exec(input word_t w);
        trace_t t;
        word_t  a;
        word_t  b;
        word_t  sx;
        word_t  zx;
        logic   known;
        a     = model_rf[w[25:21]];
        b     = model_rf[w[20:16]];
        sx    = {{16{w[15]}}, w[15:0]};
        zx    = {16'h0000, w[15:0]};
        known = 1'b1;
        t     = '0;
        t.pc  = model_pc;
        t.dst = (w[31:26] == OPC_SPECIAL) ? w[15:11] : w[20:16];
        case (w[31:26])
            OPC_SPECIAL: case (w[5:0])
                FN_ADDU: t.data = a + b;
                FN_SUBU: t.data = a - b;
                FN_AND:  t.data = a & b;
                FN_OR:   t.data = a | b;
                FN_XOR:  t.data = a ^ b;
                FN_NOR:  t.data = ~(a | b);
                FN_SLT:  t.data = {31'd0, $signed(a) < $signed(b)};
                FN_SLTU: t.data = {31'd0, a < b};
                FN_SLL:  t.data = b << w[10:6];
                FN_SRL:  t.data = b >> w[10:6];
                FN_SRA:  t.data = word_t'($signed(b) >>> w[10:6]);
                default: known = 1'b0;
            endcase
            OPC_ADDIU: t.data = a + sx;
            OPC_SLTI:  t.data = {31'd0, $signed(a) < $signed(sx)};
            OPC_SLTIU: t.data = {31'd0, a < sx};       // sign extended, unsigned compare
            OPC_ANDI:  t.data = a & zx;
            OPC_ORI:   t.data = a | zx;
            OPC_XORI:  t.data = a ^ zx;
            OPC_LUI:   t.data = {w[15:0], 16'h0000};
            default:   known = 1'b0;
        endcase
        t.wr = known && t.dst != 5'd0;
        return t;
    endfunction

    task automatic issue(input word_t w);
        trace_t t;
        t = model_exec(w);
        if (t.wr) model_rf[t.dst] = t.data;
        model_pc = model_pc + 32'd4;
        @(posedge aclk);
        inst_valid <= 1'b1;
        inst_word  <= w;
        t.due = cyc + 1 + LATENCY;   // accepted at the next edge
        exp_q.push_back(t);
    endtask

    task automatic idle(input int unsigned n);
        repeat (n) begin
            @(posedge aclk);
            inst_valid <= 1'b0;
            inst_word  <= $urandom;   // junk, must be ignored
        end
    endtask

    task automatic load_reg(input reg_addr_t r, input word_t v);
        issue(i_word(OPC_LUI, 5'd0, r, v[31:16]));
        issue(i_word(OPC_ORI, r, r, v[15:0]));
    endtask

    // outputs are settled at the falling edge
    initial begin : trace_monitor
        trace_t t;
        word_t  last_pc;
        logic   have_pc;
        have_pc = 1'b0;
        last_pc = '0;
        forever begin
            @(negedge aclk);
            cyc = cyc + 1;
            if (exp_q.size() > 0 && exp_q[0].due == cyc) begin
                t = exp_q.pop_front();
                compare_word("debug_wb_pc", debug_wb_pc, t.pc);
                compare_wen("debug_wb_rf_wen", debug_wb_rf_wen, t.wr ? 4'hf : 4'h0);
                if (t.wr) begin
                    compare_reg("debug_wb_rf_wnum", debug_wb_rf_wnum, t.dst);
                    compare_word("debug_wb_rf_wdata", debug_wb_rf_wdata, t.data);
                end
                last_pc = t.pc;
                have_pc = 1'b1;
            end else begin
                if (debug_wb_rf_wen !== 4'h0) fail_run("trace write seen with nothing due to retire");
                if (have_pc) compare_word("debug_wb_pc", debug_wb_pc, last_pc);  // bubble holds pc
            end
        end
    end

    // first trace pc is RESET_PC through the model, gaps must not advance it
    task automatic test_reset_state();
        @(negedge aclk);
        compare_wen("debug_wb_rf_wen", debug_wb_rf_wen, 4'h0);
        issue(i_word(OPC_ORI, 5'd0, 5'd1, 16'h1234));
        idle(3);
        issue(i_word(OPC_ORI, 5'd0, 5'd2, 16'h5678));
        issue(i_word(OPC_ADDIU, 5'd1, 5'd3, 16'h0001));
    endtask

    task automatic test_r_type_ops();
        for (int r = 1; r < 16; r++) load_reg(reg_addr_t'(r), $urandom);
        for (int n = 0; n < 2; n++) begin
            foreach (R_FUNCTS[k]) begin
                issue(r_word(R_FUNCTS[k], rnd_reg(1, 15), rnd_reg(1, 15), rnd_reg(9, 15),
                             5'($urandom)));
            end
        end
    endtask

    task automatic test_i_type_ops();
        foreach (I_OPCODES[k]) begin
            issue(i_word(I_OPCODES[k], rnd_reg(1, 15), rnd_reg(1, 15), {1'b1, 15'($urandom)}));
            issue(i_word(I_OPCODES[k], rnd_reg(1, 15), rnd_reg(1, 15), {1'b0, 15'($urandom)}));
        end
    endtask

    // chains where each item reads what was written d items earlier
    task automatic test_forwarding();
        reg_addr_t dst;
        reg_addr_t other;
        for (int gap = 0; gap < 2; gap++) begin
            for (int d = 1; d <= 3; d++) begin
                for (int n = 0; n < 6; n++) begin
                    dst   = reg_addr_t'(n % d + 1);
                    other = reg_addr_t'((n + 1) % d + 1);
                    if (n % 2 == 0) issue(i_word(OPC_ADDIU, dst, dst, 16'($urandom)));
                    else issue(r_word(FN_SUBU, dst, other, dst, 5'd0));
                    idle(gap);
                end
            end
        end
    endtask

    task automatic test_zero_and_unknown();
        issue(i_word(OPC_ADDIU, 5'd1, 5'd0, 16'h7fff));
        issue(r_word(FN_OR, 5'd1, 5'd2, 5'd0, 5'd0));
        issue(r_word(FN_ADDU, 5'd0, 5'd0, 5'd4, 5'd0));   // $0 still reads zero
        issue(i_word(OPC_ORI, 5'd0, 5'd5, 16'h0000));
        issue({6'h23, 26'($urandom)});                    // lw, not kept
        issue({6'h02, 26'($urandom)});                    // j
        issue({6'h3f, 26'($urandom)});
        issue(r_word(6'h3e, 5'd1, 5'd2, 5'd6, 5'd0));
    endtask

    task automatic test_random_stream();
        int unsigned k;
        repeat (200) begin
            if ($urandom_range(1, 0) == 0) begin
                k = $urandom_range(10, 0);
                issue(r_word(R_FUNCTS[k], rnd_reg(0, 15), rnd_reg(0, 15), rnd_reg(0, 15),
                             5'($urandom)));
            end else begin
                k = $urandom_range(6, 0);
                issue(i_word(I_OPCODES[k], rnd_reg(0, 15), rnd_reg(0, 15), 16'($urandom)));
            end
            if ($urandom_range(3, 0) == 0) idle($urandom_range(2, 1));
        end
    endtask

    initial begin
        arst_n     = 1'b0;
        inst_valid = 1'b0;
        inst_word  = '0;
        model_pc   = RESET_PC;
        foreach (model_rf[k]) model_rf[k] = '0;
        void'($urandom(SEED));
        repeat (16) @(posedge aclk);
        arst_n <= 1'b1;
        test_reset_state();
        test_r_type_ops();
        test_i_type_ops();
        test_forwarding();
        test_zero_and_unknown();
        test_random_stream();
        idle(LATENCY + 2);
        if (exp_q.size() == 0) begin
            $display("Regression passed");
            $finish;
        end else begin
            fail_run("instructions issued but never retired on the trace port");
        end
    end

endmodule

`default_nettype wire

//--- files.f
src/cpu_pkg.sv
src/pipe_if.sv
src/decode_stage.sv
src/execute_stage.sv
src/result_stage.sv
src/mini_mips_top.sv
dv/mini_mips_sva.sv
dv/tb_mini_mips.sv

//--- src/cpu_pkg.sv
// shared types and MIPS32 encodings for the core, imported by every stage and both interfaces
`default_nettype none

package cpu_pkg;

    localparam int WORD_W     = 32;
    localparam int REG_ADDR_W = 5;
    localparam int SHAMT_W    = 5;
    localparam int NUM_REGS   = 32;

    typedef logic [WORD_W-1:0]     word_t;      // data, pc or instruction
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    // register format
    typedef struct packed {
        logic [5:0]         opcode;
        reg_addr_t          rs;
        reg_addr_t          rt;
        reg_addr_t          rd;
        logic [SHAMT_W-1:0] shamt;
        logic [5:0]         funct;
    } r_fmt_t;

    // immediate format
    typedef struct packed {
        logic [5:0]  opcode;
        reg_addr_t   rs;
        reg_addr_t   rt;
        logic [15:0] imm;
    } i_fmt_t;

    // one word, two views; opcode decides which one means something
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
    } instr_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_NOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_LUI
    } alu_op_e;

    // opcodes
    localparam logic [5:0] OPC_SPECIAL = 6'h00;
    localparam logic [5:0] OPC_ADDIU   = 6'h09;
    localparam logic [5:0] OPC_SLTI    = 6'h0a;
    localparam logic [5:0] OPC_SLTIU   = 6'h0b;
    localparam logic [5:0] OPC_ANDI    = 6'h0c;
    localparam logic [5:0] OPC_ORI     = 6'h0d;
    localparam logic [5:0] OPC_XORI    = 6'h0e;
    localparam logic [5:0] OPC_LUI     = 6'h0f;

    // funct field of SPECIAL
    localparam logic [5:0] FN_SLL  = 6'h00;
    localparam logic [5:0] FN_SRL  = 6'h02;
    localparam logic [5:0] FN_SRA  = 6'h03;
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_XOR  = 6'h26;
    localparam logic [5:0] FN_NOR  = 6'h27;
    localparam logic [5:0] FN_SLT  = 6'h2a;
    localparam logic [5:0] FN_SLTU = 6'h2b;

    localparam word_t DEFAULT_RESET_PC = 32'hbfc0_0000;  // kseg1 boot vector

endpackage

`default_nettype wire

//--- src/decode_stage.sv
// first stage: pc counter, register file and decode of the incoming word into an ALU op
`timescale 1ns/1ps
`default_nettype none

module decode_stage #(
    parameter cpu_pkg::word_t RESET_PC = cpu_pkg::DEFAULT_RESET_PC
) (
    input  logic               aclk,
    input  logic               arst_n,
    input  logic               inst_valid,
    input  cpu_pkg::word_t     inst_word,
    input  logic               wb_wen,
    input  cpu_pkg::reg_addr_t wb_dst,
    input  cpu_pkg::word_t     wb_data,
    dec_exe_if.dec             dx
);
    import cpu_pkg::*;

    word_t     pc_q;                 // pc of the next accepted word
    word_t     rf [NUM_REGS];
    instr_t    ins;
    alu_op_e   op;
    logic      use_imm;
    logic      sign_ext;
    logic      dst_is_rd;
    logic      known;
    word_t     imm_ext;
    reg_addr_t dst;

    assign ins = inst_word;

    // register file read, bypassing a write in the same cycle
    function automatic word_t rf_read(input reg_addr_t a);
        word_t v;
        if (a == '0) begin
            v = '0;
        end else if (wb_wen && wb_dst == a) begin
            v = wb_data;
        end else begin
            v = rf[a];
        end
        return v;
    endfunction

    always_comb begin
        op        = ALU_ADD;
        use_imm   = 1'b1;
        sign_ext  = 1'b0;
        dst_is_rd = 1'b0;
        known     = 1'b1;
        case (ins.i.opcode)
            OPC_SPECIAL: begin
                use_imm   = 1'b0;
                dst_is_rd = 1'b1;
                case (ins.r.funct)
                    FN_ADDU: op = ALU_ADD;
                    FN_SUBU: op = ALU_SUB;
                    FN_AND:  op = ALU_AND;
                    FN_OR:   op = ALU_OR;
                    FN_XOR:  op = ALU_XOR;
                    FN_NOR:  op = ALU_NOR;
                    FN_SLT:  op = ALU_SLT;
                    FN_SLTU: op = ALU_SLTU;
                    FN_SLL:  op = ALU_SLL;
                    FN_SRL:  op = ALU_SRL;
                    FN_SRA:  op = ALU_SRA;
                    default: known = 1'b0;
                endcase
            end
            OPC_ADDIU: begin
                op       = ALU_ADD;
                sign_ext = 1'b1;
            end
            OPC_SLTI: begin
                op       = ALU_SLT;
                sign_ext = 1'b1;
            end
            OPC_SLTIU: begin
                op       = ALU_SLTU;
                sign_ext = 1'b1;          // extended signed, compared unsigned
            end
            OPC_ANDI: op = ALU_AND;
            OPC_ORI:  op = ALU_OR;
            OPC_XORI: op = ALU_XOR;
            OPC_LUI:  op = ALU_LUI;
            default:  known = 1'b0;
        endcase
    end

    assign imm_ext = sign_ext ? {{16{ins.i.imm[15]}}, ins.i.imm} : {16'h0000, ins.i.imm};
    assign dst     = dst_is_rd ? ins.r.rd : ins.i.rt;

    // write port, $0 is never stored
    always_ff @(posedge aclk) begin
        if (wb_wen && wb_dst != '0) begin
            rf[wb_dst] <= wb_data;
        end
    end

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            pc_q     <= RESET_PC;
            dx.valid <= 1'b0;
            dx.wen   <= 1'b0;
        end else begin
            if (inst_valid) begin
                pc_q <= pc_q + 32'd4;
            end
            dx.valid <= inst_valid;
            dx.wen   <= inst_valid && known && (dst != '0);
        end
    end

    // payload, meaningful only with valid
    always_ff @(posedge aclk) begin
        dx.pc      <= pc_q;
        dx.alu_op  <= op;
        dx.rs      <= ins.r.rs;
        dx.rt      <= ins.r.rt;
        dx.rs_val  <= rf_read(ins.r.rs);
        dx.rt_val  <= rf_read(ins.r.rt);
        dx.imm     <= imm_ext;
        dx.use_imm <= use_imm;
        dx.shamt   <= ins.r.shamt;
        dx.dst     <= dst;
    end

endmodule

`default_nettype wire

//--- src/execute_stage.sv
// second stage: picks the newest operands and runs the ALU, result goes to the result stage
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
    input  logic               aclk,
    input  logic               arst_n,
    dec_exe_if.exe             dx,
    exe_res_if.exe             xr,
    input  logic               wb_wen,
    input  cpu_pkg::reg_addr_t wb_dst,
    input  cpu_pkg::word_t     wb_data
);
    import cpu_pkg::*;

    word_t op_a;
    word_t op_b;
    word_t rt_fwd;
    word_t alu_res;
    logic  lt_s;
    logic  lt_u;

    // newest copy of a source: item ahead of us, then write-back, then decode read
    function automatic word_t fwd(input reg_addr_t src, input word_t rf_val);
        word_t v;
        if (src != '0 && xr.wen && xr.dst == src) begin
            v = xr.result;
        end else if (src != '0 && wb_wen && wb_dst == src) begin
            v = wb_data;
        end else begin
            v = rf_val;
        end
        return v;
    endfunction

    assign op_a   = fwd(dx.rs, dx.rs_val);
    assign rt_fwd = fwd(dx.rt, dx.rt_val);
    assign op_b   = dx.use_imm ? dx.imm : rt_fwd;

    assign lt_s = $signed(op_a) < $signed(op_b);
    assign lt_u = op_a < op_b;

    always_comb begin
        case (dx.alu_op)
            ALU_ADD:  alu_res = op_a + op_b;
            ALU_SUB:  alu_res = op_a - op_b;
            ALU_AND:  alu_res = op_a & op_b;
            ALU_OR:   alu_res = op_a | op_b;
            ALU_XOR:  alu_res = op_a ^ op_b;
            ALU_NOR:  alu_res = ~(op_a | op_b);
            ALU_SLT:  alu_res = {{(WORD_W-1){1'b0}}, lt_s};
            ALU_SLTU: alu_res = {{(WORD_W-1){1'b0}}, lt_u};
            ALU_SLL:  alu_res = op_b << dx.shamt;      // shifts work on rt
            ALU_SRL:  alu_res = op_b >> dx.shamt;
            ALU_SRA:  alu_res = word_t'($signed(op_b) >>> dx.shamt);
            ALU_LUI:  alu_res = {op_b[15:0], 16'h0000};
            default:  alu_res = '0;
        endcase
    end

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            xr.valid <= 1'b0;
            xr.wen   <= 1'b0;
        end else begin
            xr.valid <= dx.valid;
            xr.wen   <= dx.wen;   // already low for bubbles
        end
    end

    always_ff @(posedge aclk) begin
        xr.pc     <= dx.pc;
        xr.result <= alu_res;
        xr.dst    <= dx.dst;
    end

endmodule

`default_nettype wire

//--- src/mini_mips_top.sv
// core top level: three pipeline stages behind the instruction strobe and the trace port
`timescale 1ns/1ps
`default_nettype none

module mini_mips_top #(
    parameter cpu_pkg::word_t RESET_PC = cpu_pkg::DEFAULT_RESET_PC
) (
    input  logic               aclk,
    input  logic               arst_n,
    input  logic               inst_valid,
    input  cpu_pkg::word_t     inst_word,
    output cpu_pkg::word_t     debug_wb_pc,
    output cpu_pkg::word_t     debug_wb_rf_wdata,
    output logic [3:0]         debug_wb_rf_wen,
    output cpu_pkg::reg_addr_t debug_wb_rf_wnum
);
    import cpu_pkg::*;

    logic      wb_wen;     // write-back port, also the second forwarding source
    reg_addr_t wb_dst;
    word_t     wb_data;

    dec_exe_if i_dx ();
    exe_res_if i_xr ();

    decode_stage #(
        .RESET_PC   (RESET_PC)
    ) i_decode_stage (
        .aclk       (aclk),
        .arst_n     (arst_n),
        .inst_valid (inst_valid),
        .inst_word  (inst_word),
        .wb_wen     (wb_wen),
        .wb_dst     (wb_dst),
        .wb_data    (wb_data),
        .dx         (i_dx.dec)
    );

    execute_stage i_execute_stage (
        .aclk       (aclk),
        .arst_n     (arst_n),
        .dx         (i_dx.exe),
        .xr         (i_xr.exe),
        .wb_wen     (wb_wen),
        .wb_dst     (wb_dst),
        .wb_data    (wb_data)
    );

    result_stage i_result_stage (
        .aclk       (aclk),
        .arst_n     (arst_n),
        .xr         (i_xr.res),
        .wb_wen     (wb_wen),
        .wb_dst     (wb_dst),
        .wb_data    (wb_data),
        .trace_pc   (debug_wb_pc),
        .trace_wen  (debug_wb_rf_wen)
    );

    assign debug_wb_rf_wdata = wb_data;
    assign debug_wb_rf_wnum  = wb_dst;

endmodule

`default_nettype wire

//--- src/pipe_if.sv
// stage-to-stage buses of the pipeline, decode to execute and execute to result
`timescale 1ns/1ps
`default_nettype none

interface dec_exe_if;
    import cpu_pkg::*;

    logic               valid;
    word_t              pc;
    alu_op_e            alu_op;
    reg_addr_t          rs;      // source numbers, kept for forwarding
    reg_addr_t          rt;
    word_t              rs_val;
    word_t              rt_val;
    word_t              imm;     // already extended
    logic               use_imm;
    logic [SHAMT_W-1:0] shamt;
    reg_addr_t          dst;
    logic               wen;

    modport dec (output valid, pc, alu_op, rs, rt, rs_val, rt_val, imm, use_imm, shamt, dst,
                 wen);
    modport exe (input  valid, pc, alu_op, rs, rt, rs_val, rt_val, imm, use_imm, shamt, dst,
                 wen);
endinterface

interface exe_res_if;
    import cpu_pkg::*;

    logic      valid;
    word_t     pc;
    word_t     result;
    reg_addr_t dst;
    logic      wen;

    modport exe (output valid, pc, result, dst, wen);
    modport res (input  valid, pc, result, dst, wen);
endinterface

`default_nettype wire

//--- src/result_stage.sv
// last stage: drives the register-file write port and the golden-trace signals
`timescale 1ns/1ps
`default_nettype none

module result_stage (
    input  logic                aclk,
    input  logic                arst_n,
    exe_res_if.res              xr,
    output logic                wb_wen,
    output cpu_pkg::reg_addr_t  wb_dst,
    output cpu_pkg::word_t      wb_data,
    output cpu_pkg::word_t      trace_pc,
    output logic [3:0]          trace_wen
);
    import cpu_pkg::*;

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            wb_wen <= 1'b0;
        end else begin
            wb_wen <= xr.wen;
        end
    end

    always_ff @(posedge aclk) begin
        wb_dst  <= xr.dst;
        wb_data <= xr.result;
        if (xr.valid) begin
            trace_pc <= xr.pc;    // holds across bubbles
        end
    end

    assign trace_wen = {4{wb_wen}};  // whole word or nothing

endmodule

`default_nettype wire
